/* sim.f */
src/cache_pkg.sv
src/way_if.sv
src/mem_if.sv
src/cache_way.sv
src/banked_mem.sv
src/cache_ctrl.sv
src/mem_system.sv
test/mem_system_chk.sv
test/mem_system_tb.sv

/* Bender.yml */
package:
  name: mem_system

sources:
  - src/cache_pkg.sv
  - src/way_if.sv
  - src/mem_if.sv
  - src/cache_way.sv
  - src/banked_mem.sv
  - src/cache_ctrl.sv
  - src/mem_system.sv
  - target: test
    files:
      - test/mem_system_chk.sv
      - test/mem_system_tb.sv

/* test/mem_system_tb.sv */
/*
 * Memory system testbench
 * Directed tests of the two-way cache against a shadow memory,
 * plus LFSR driven random traffic
 */
`timescale 1ns/1ps

module mem_system_tb;

   localparam int clk_period   = 20;
   localparam int req_limit    = 200;
   localparam int num_requests = 224;
   localparam int watchdog_ns  = (num_requests * req_limit + 10) * clk_period;

   logic        clk = 1'b0;
   logic        rst_n;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;

   logic [15:0] shadow [logic [14:0]];
   logic [31:0] lfsr_q = 32'h069f_be7a;

   mem_system i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic report_mismatch(input string sig, input logic [15:0] exp_v,
                                  input logic [15:0] act_v);
      $display("MISMATCH at %0d ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
      abort_run();
   endtask

   // Galois form, one step per bit taken
   function automatic logic [15:0] lfsr_take(input int n);
      logic [15:0] v;
      logic        b;
      v = '0;
      for (int i = 0; i < n; i++) begin
         b = lfsr_q[0];
         lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
         v = {v[14:0], b};
      end
      return v;
   endfunction

   function automatic logic [15:0] shadow_get(input logic [15:0] a);
      return shadow.exists(a[15:1]) ? shadow[a[15:1]] : 16'h0000;
   endfunction

   // Presents one request for a single cycle
   task automatic issue(input logic [15:0] a, input logic [15:0] d, input logic is_wr);
      addr    = a;
      data_in = d;
      rd      = ~is_wr;
      wr      = is_wr;
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   task automatic wait_done(input logic [15:0] a);
      int cycles;
      cycles = 0;
      while (done !== 1'b1) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > req_limit) begin
            $display("Request to address %h got no done within %0d cycles", a, req_limit);
            abort_run();
         end
      end
   endtask

   task automatic do_read(input logic [15:0] a, input bit chk_hit, input bit exp_hit);
      logic [15:0] exp_data;
      exp_data = shadow_get(a);
      issue(a, 16'h0000, 1'b0);
      wait_done(a);
      assert (data_out === exp_data) else report_mismatch("data_out", exp_data, data_out);
      if (chk_hit) begin
         assert (cache_hit === exp_hit) else report_mismatch("cache_hit", exp_hit, cache_hit);
      end
   endtask

   task automatic do_write(input logic [15:0] a, input logic [15:0] d, input bit chk_hit,
                           input bit exp_hit);
      shadow[a[15:1]] = d;
      issue(a, d, 1'b1);
      wait_done(a);
      if (chk_hit) begin
         assert (cache_hit === exp_hit) else report_mismatch("cache_hit", exp_hit, cache_hit);
      end
   endtask

   task automatic cold_read_test();
      do_read(16'h0010, 1'b1, 1'b0);
      do_read(16'h0010, 1'b1, 1'b1);
      do_read(16'h0012, 1'b1, 1'b1);
      do_read(16'h0014, 1'b1, 1'b1);
      do_read(16'h0016, 1'b1, 1'b1);
   endtask

   task automatic write_read_test();
      do_write(16'h0124, 16'h1234, 1'b1, 1'b0);
      do_read(16'h0124, 1'b1, 1'b1);
      do_write(16'h0124, 16'hbeef, 1'b1, 1'b1);
      do_read(16'h0124, 1'b1, 1'b1);
   endtask

   // Same index 0x50, tags 4 and 9
   task automatic two_way_test();
      do_read(16'h2280, 1'b1, 1'b0);
      // A miss to set 0x60 in between flips the victim pointer
      do_read(16'h0300, 1'b1, 1'b0);
      do_read(16'h4a80, 1'b1, 1'b0);
      for (int i = 0; i < 2; i++) begin
         do_read(16'h2280, 1'b1, 1'b1);
         do_read(16'h4a80, 1'b1, 1'b1);
      end
   endtask

   // Three tags in set 0x40, so one dirty line must go back to memory
   task automatic eviction_test();
      do_write(16'h0a00, 16'ha5a1, 1'b0, 1'b0);
      do_write(16'h1200, 16'h5a52, 1'b0, 1'b0);
      do_write(16'h1a00, 16'hc3c3, 1'b0, 1'b0);
      do_read(16'h0a00, 1'b0, 1'b0);
      do_read(16'h1200, 1'b0, 1'b0);
      do_read(16'h1a00, 1'b0, 1'b0);
   endtask

   task automatic hit_timing(input logic [15:0] a, input logic [15:0] d, input logic is_wr);
      logic [15:0] exp_data;
      if (is_wr) begin
         shadow[a[15:1]] = d;
      end
      exp_data = shadow_get(a);
      issue(a, d, is_wr);
      // Two edges after the sampling edge and no sooner
      for (int e = 0; e < 2; e++) begin
         assert (stall === 1'b0) else report_mismatch("stall", 16'h0, stall);
         assert (done === 1'b0) else report_mismatch("done", 16'h0, done);
         @(posedge clk);
         #1;
      end
      assert (done === 1'b1) else report_mismatch("done", 16'h1, done);
      assert (stall === 1'b0) else report_mismatch("stall", 16'h0, stall);
      assert (cache_hit === 1'b1) else report_mismatch("cache_hit", 16'h1, cache_hit);
      if (!is_wr) begin
         assert (data_out === exp_data) else report_mismatch("data_out", exp_data, data_out);
      end
   endtask

   task automatic hit_timing_test();
      hit_timing(16'h0010, 16'h0000, 1'b0);
      hit_timing(16'h0016, 16'h7e57, 1'b1);
   endtask

   task automatic random_test();
      logic        is_wr;
      logic [15:0] a;
      logic [15:0] d;
      logic [15:0] r;
      for (int n = 0; n < 200; n++) begin
         r        = lfsr_take(1);
         is_wr    = r[0];
         r        = lfsr_take(2);
         a[2:0]   = {r[1:0], 1'b0};
         r        = lfsr_take(2);
         a[10:3]  = {6'h30, r[1:0]};
         r        = lfsr_take(3);
         a[15:11] = {2'b10, r[2:0]};
         if (is_wr) begin
            d = lfsr_take(16);
            do_write(a, d, 1'b0, 1'b0);
         end else begin
            do_read(a, 1'b0, 1'b0);
         end
      end
   endtask

   initial begin
      #(watchdog_ns);
      $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
      abort_run();
   end

   initial begin
      wait (i_dut.i_chk.err_cnt != 0);
      #1;
      $display("Protocol checker reported a failed assertion");
      abort_run();
   end

   initial begin
      rst_n   = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;

      cold_read_test();
      write_read_test();
      two_way_test();
      eviction_test();
      hit_timing_test();
      random_test();

      repeat (2) @(posedge clk);
      #1;
      if (i_dut.i_chk.err_cnt == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         $display("Protocol checker reported a failed assertion");
         abort_run();
      end
   end

endmodule

/* test/mem_system_chk.sv */
/*
 * Host protocol checker
 * Bound into the memory system top; watches done, stall and the
 * capture of host requests
 */
`timescale 1ns/1ps

module mem_system_chk (
   input logic clk,
   input logic rst_n,
   input logic rd,
   input logic wr,
   input logic stall,
   input logic done
);

   logic [1:0] open_q;
   int         err_cnt = 0;

   // Requests captured while not stalled and not yet answered by done
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         open_q <= '0;
      end else begin
         open_q <= open_q + {1'b0, (rd | wr) & ~stall} - {1'b0, done};
      end
   end

   done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else begin
         $error("done stayed high for two cycles");
         err_cnt++;
      end

   done_no_stall: assert property (@(posedge clk) disable iff (!rst_n) done |-> !stall)
      else begin
         $error("stall high together with done");
         err_cnt++;
      end

   done_has_req: assert property (@(posedge clk) disable iff (!rst_n) done |-> open_q != '0)
      else begin
         $error("done without a captured request");
         err_cnt++;
      end

endmodule

bind mem_system mem_system_chk i_chk (
   .clk   (clk),
   .rst_n (rst_n),
   .rd    (rd),
   .wr    (wr),
   .stall (stall),
   .done  (done)
);

/* src/mem_system.sv */
/*
 * Memory system top
 * Two-way write-back data cache in front of a four-bank main memory,
 * with the host stall/done request protocol
 */
`timescale 1ns/1ps

module mem_system (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [cache_pkg::addr_w-1:0] addr,
   input  logic [cache_pkg::data_w-1:0] data_in,
   input  logic                         rd,
   input  logic                         wr,
   output logic [cache_pkg::data_w-1:0] data_out,
   output logic                         done,
   output logic                         stall,
   output logic                         cache_hit
);

   way_if way0_bus ();
   way_if way1_bus ();
   mem_if mem_bus ();

   cache_ctrl i_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .way0      (way0_bus.ctrl),
      .way1      (way1_bus.ctrl),
      .mem       (mem_bus.ctrl)
   );

   cache_way i_way0 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way0_bus.way)
   );

   cache_way i_way1 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way1_bus.way)
   );

   banked_mem i_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mem_bus.memory)
   );

endmodule

/* src/cache_ctrl.sv */
/*
 * Cache controller
 * Registers host requests, looks both ways up, and on a miss writes
 * back a dirty victim, refills the line from memory and retries
 */
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [cache_pkg::addr_w-1:0] addr,
   input  logic [cache_pkg::data_w-1:0] data_in,
   input  logic                         rd,
   input  logic                         wr,
   output logic [cache_pkg::data_w-1:0] data_out,
   output logic                         done,
   output logic                         stall,
   output logic                         cache_hit,
   way_if.ctrl                          way0,
   way_if.ctrl                          way1,
   mem_if.ctrl                          mem
);

   cache_pkg::ctrl_state_e state_q;

   logic [cache_pkg::addr_w-1:0]   in_addr_q;
   logic [cache_pkg::addr_w-1:0]   op_addr_q;
   logic [cache_pkg::addr_w-1:0]   cur_addr;
   logic [cache_pkg::data_w-1:0]   in_data_q;
   logic [cache_pkg::data_w-1:0]   op_data_q;
   logic                           in_rd_q;
   logic                           in_wr_q;
   logic                           op_wr_q;
   logic                           victim_q;
   logic                           ptr_q;
   logic                           victim_sel;
   logic                           vic_dirty;
   logic [$clog2(cache_pkg::line_words)-1:0] iss_cnt_q;
   logic [$clog2(cache_pkg::line_words)-1:0] ret_cnt_q;
   logic [cache_pkg::mem_rd_lat-1:0]         acc_q;
   logic                           req;
   logic                           hit_any;
   logic                           mem_acc;
   logic                           rvalid;
   logic                           retry_go;
   logic                           way_en;
   logic                           way_cmp;
   logic                           way_wr;
   logic [cache_pkg::offset_w-1:0] way_off;
   logic [cache_pkg::data_w-1:0]   way_din;
   logic [cache_pkg::tag_w-1:0]    cur_tag;
   logic [cache_pkg::tag_w-1:0]    vic_tag;
   logic [cache_pkg::index_w-1:0]  cur_index;
   logic [cache_pkg::data_w-1:0]   vic_data;
   logic [cache_pkg::data_w-1:0]   hit_data;

   assign req       = in_rd_q | in_wr_q;
   assign cur_addr  = (state_q == cache_pkg::st_idle) ? in_addr_q : op_addr_q;
   assign cur_tag   = cur_addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
   assign cur_index = cur_addr[cache_pkg::offset_w +: cache_pkg::index_w];

   assign hit_any  = way0.hit | way1.hit;
   assign hit_data = way1.hit ? way1.data_out : way0.data_out;

   // Invalid way first, then the toggling pointer
   assign victim_sel = ~way0.valid ? 1'b0 : (~way1.valid ? 1'b1 : ptr_q);
   assign vic_dirty  = victim_sel ? way1.dirty : way0.dirty;
   assign vic_tag    = victim_q ? way1.tag_out : way0.tag_out;
   assign vic_data   = victim_q ? way1.data_out : way0.data_out;

   assign rvalid   = acc_q[cache_pkg::mem_rd_lat-1];
   assign retry_go = ~|mem.busy;

   always_comb begin
      way_en  = 1'b1;
      way_cmp = 1'b0;
      way_wr  = 1'b0;
      way_off = cur_addr[cache_pkg::offset_w-1:0];
      way_din = op_data_q;
      case (state_q)
         cache_pkg::st_idle: begin
            way_en  = req;
            way_cmp = 1'b1;
         end
         cache_pkg::st_compare: begin
            way_cmp = 1'b1;
            way_wr  = op_wr_q;
         end
         cache_pkg::st_wb: begin
            way_off = {iss_cnt_q, 1'b0};
         end
         cache_pkg::st_fill, cache_pkg::st_fill_wait: begin
            way_off = {ret_cnt_q, 1'b0};
            way_din = mem.rdata;
            way_wr  = rvalid;
         end
         cache_pkg::st_retry: begin
            way_cmp = 1'b1;
            way_wr  = op_wr_q & retry_go;
         end
         default: begin
            way_en = 1'b0;
         end
      endcase
   end

   assign way0.enable  = way_en;
   assign way0.comp    = way_cmp;
   assign way0.write   = way_wr & (way_cmp | ~victim_q);
   assign way0.tag_in  = cur_tag;
   assign way0.index   = cur_index;
   assign way0.offset  = way_off;
   assign way0.data_in = way_din;

   assign way1.enable  = way_en;
   assign way1.comp    = way_cmp;
   assign way1.write   = way_wr & (way_cmp | victim_q);
   assign way1.tag_in  = cur_tag;
   assign way1.index   = cur_index;
   assign way1.offset  = way_off;
   assign way1.data_in = way_din;

   // Write-back goes to the victim's old tag, the fill to the new one
   assign mem.wr    = (state_q == cache_pkg::st_wb);
   assign mem.rd    = (state_q == cache_pkg::st_fill);
   assign mem.addr  = {((state_q == cache_pkg::st_wb) ? vic_tag : cur_tag), cur_index, iss_cnt_q};
   assign mem.wdata = vic_data;
   assign mem_acc   = (state_q == cache_pkg::st_wb || state_q == cache_pkg::st_fill) & ~mem.stall;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_rd_q <= 1'b0;
         in_wr_q <= 1'b0;
      end else if (!stall) begin
         in_rd_q <= rd;
         in_wr_q <= wr;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         in_addr_q <= addr;
         in_data_q <= data_in;
      end
      if (state_q == cache_pkg::st_idle && req) begin
         op_addr_q <= in_addr_q;
         op_data_q <= in_data_q;
      end
      if (!op_wr_q && (state_q == cache_pkg::st_compare ||
                       (state_q == cache_pkg::st_retry && retry_go))) begin
         data_out <= hit_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= cache_pkg::st_idle;
         done      <= 1'b0;
         stall     <= 1'b0;
         cache_hit <= 1'b0;
         op_wr_q   <= 1'b0;
         victim_q  <= 1'b0;
         ptr_q     <= 1'b0;
         iss_cnt_q <= '0;
         ret_cnt_q <= '0;
         acc_q     <= '0;
      end else begin
         done <= 1'b0;
         acc_q[0] <= mem_acc & mem.rd;
         for (int i = 1; i < cache_pkg::mem_rd_lat; i++) begin
            acc_q[i] <= acc_q[i-1];
         end
         if (mem_acc) begin
            iss_cnt_q <= iss_cnt_q + 1'b1;
         end
         if (rvalid) begin
            ret_cnt_q <= ret_cnt_q + 1'b1;
         end
         case (state_q)
            cache_pkg::st_idle: begin
               if (req) begin
                  op_wr_q  <= in_wr_q;
                  victim_q <= victim_sel;
                  if (hit_any) begin
                     state_q <= cache_pkg::st_compare;
                  end else begin
                     stall   <= 1'b1;
                     state_q <= vic_dirty ? cache_pkg::st_wb : cache_pkg::st_fill;
                  end
               end
            end
            cache_pkg::st_compare: begin
               done      <= 1'b1;
               cache_hit <= 1'b1;
               state_q   <= cache_pkg::st_idle;
            end
            cache_pkg::st_wb: begin
               if (mem_acc && &iss_cnt_q) begin
                  state_q <= cache_pkg::st_fill;
               end
            end
            cache_pkg::st_fill: begin
               if (mem_acc && &iss_cnt_q) begin
                  state_q <= cache_pkg::st_fill_wait;
               end
            end
            cache_pkg::st_fill_wait: begin
               if (rvalid && &ret_cnt_q) begin
                  ptr_q   <= ~ptr_q;
                  state_q <= cache_pkg::st_retry;
               end
            end
            cache_pkg::st_retry: begin
               // Let all banks drain so the next miss starts on a quiet memory
               if (retry_go) begin
                  done      <= 1'b1;
                  cache_hit <= 1'b0;
                  stall     <= 1'b0;
                  state_q   <= cache_pkg::st_finish;
               end
            end
            default: begin
               state_q <= cache_pkg::st_idle;
            end
         endcase
      end
   end

endmodule

/* src/banked_mem.sv */
/*
 * Banked main memory
 * Four interleaved word banks with a fixed read latency; a bank stays
 * busy for a few cycles after each access and stalls new requests to it
 */
`timescale 1ns/1ps

module banked_mem (
   input  logic    clk,
   input  logic    rst_n,
   mem_if.memory   bus
);

   typedef logic [$clog2(cache_pkg::bank_busy_cycles+1)-1:0] busy_cnt_t;

   logic [cache_pkg::data_w-1:0] mem_q [cache_pkg::mem_words] = '{default: '0};
   logic [cache_pkg::data_w-1:0] pipe_q [cache_pkg::mem_rd_lat];

   busy_cnt_t                                busy_cnt_q [cache_pkg::num_banks];
   logic [$clog2(cache_pkg::num_banks)-1:0]  bank;
   logic [cache_pkg::num_banks-1:0]          bank_hot;
   logic                                     acc;

   // Word address bits 1..0 pick the bank
   assign bank = bus.addr[$clog2(cache_pkg::num_banks)-1:0];

   always_comb begin
      for (int b = 0; b < cache_pkg::num_banks; b++) begin
         bus.busy[b] = (busy_cnt_q[b] != '0);
      end
   end

   assign bus.stall = (bus.rd | bus.wr) & bus.busy[bank];
   assign acc       = (bus.rd | bus.wr) & ~bus.stall;
   assign bank_hot  = acc ? ({{(cache_pkg::num_banks-1){1'b0}}, 1'b1} << bank) : '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int b = 0; b < cache_pkg::num_banks; b++) begin
            busy_cnt_q[b] <= '0;
         end
      end else begin
         for (int b = 0; b < cache_pkg::num_banks; b++) begin
            if (bank_hot[b]) begin
               busy_cnt_q[b] <= busy_cnt_t'(cache_pkg::bank_busy_cycles);
            end else if (busy_cnt_q[b] != '0) begin
               busy_cnt_q[b] <= busy_cnt_q[b] - 1'b1;
            end
         end
      end
   end

   // Storage and read delay line
   always_ff @(posedge clk) begin
      if (acc && bus.wr) begin
         mem_q[bus.addr] <= bus.wdata;
      end
      if (acc && bus.rd) begin
         pipe_q[0] <= mem_q[bus.addr];
      end
      for (int i = 1; i < cache_pkg::mem_rd_lat; i++) begin
         pipe_q[i] <= pipe_q[i-1];
      end
   end

   // Banks are interleaved, so reads to different banks overlap
   assign bus.rdata = pipe_q[cache_pkg::mem_rd_lat-1];

endmodule

/* src/cache_way.sv */
/*
 * Cache way
 * One way of the set-associative cache: tag, valid and dirty per set,
 * a word-addressed data array and the tag compare
 */
`timescale 1ns/1ps

module cache_way (
   input  logic clk,
   input  logic rst_n,
   way_if.way   bus
);

   logic [cache_pkg::tag_w-1:0]      tag_q   [2**cache_pkg::index_w];
   logic [2**cache_pkg::index_w-1:0] valid_q;
   logic [2**cache_pkg::index_w-1:0] dirty_q;
   logic [cache_pkg::data_w-1:0]
      data_q [2**cache_pkg::index_w * cache_pkg::line_words];

   logic [cache_pkg::index_w+$clog2(cache_pkg::line_words)-1:0] word_idx;
   logic                                                          tag_eq;
   logic                                                          cmp_wr;
   logic                                                          fill_wr;

   // Byte offset bit 0 is dropped, words sit at even offsets
   assign word_idx = {bus.index, bus.offset[cache_pkg::offset_w-1:1]};

   assign tag_eq  = (tag_q[bus.index] == bus.tag_in);
   assign bus.hit = bus.enable & bus.comp & valid_q[bus.index] & tag_eq;

   assign bus.valid    = valid_q[bus.index];
   assign bus.dirty    = dirty_q[bus.index];
   assign bus.tag_out  = tag_q[bus.index];
   assign bus.data_out = data_q[word_idx];

   // Compare write lands only on a hit
   assign cmp_wr  = bus.enable & bus.write & bus.hit;
   assign fill_wr = bus.enable & bus.write & ~bus.comp;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (fill_wr) begin
         valid_q[bus.index] <= 1'b1;
         dirty_q[bus.index] <= 1'b0;
      end else if (cmp_wr) begin
         dirty_q[bus.index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_wr) begin
         tag_q[bus.index] <= bus.tag_in;
      end
      if (fill_wr || cmp_wr) begin
         data_q[word_idx] <= bus.data_in;
      end
   end

endmodule

/* src/mem_if.sv */
/*
 * Banked memory bus
 * Word requests from the controller, read data and bank status back
 */
`timescale 1ns/1ps

interface mem_if;

   // Word address, one bit narrower than the byte address
   logic [cache_pkg::addr_w-2:0]    addr;
   logic [cache_pkg::data_w-1:0]    wdata;
   logic                            rd;
   logic                            wr;

   logic [cache_pkg::data_w-1:0]    rdata;
   logic                            stall;
   logic [cache_pkg::num_banks-1:0] busy;

   modport ctrl (
      output addr, wdata, rd, wr,
      input  rdata, stall, busy
   );

   modport memory (
      input  addr, wdata, rd, wr,
      output rdata, stall, busy
   );

endinterface

/* src/way_if.sv */
/*
 * Cache way access bus
 * Lookup and write signals between the controller and one way
 */
`timescale 1ns/1ps

interface way_if;

   // Driven by the controller
   logic                           enable;
   logic                           comp;
   logic                           write;
   logic [cache_pkg::tag_w-1:0]    tag_in;
   logic [cache_pkg::index_w-1:0]  index;
   logic [cache_pkg::offset_w-1:0] offset;
   logic [cache_pkg::data_w-1:0]   data_in;

   // Driven by the way, combinational from index and offset
   logic                           hit;
   logic                           dirty;
   logic                           valid;
   logic [cache_pkg::tag_w-1:0]    tag_out;
   logic [cache_pkg::data_w-1:0]   data_out;

   modport ctrl (
      output enable, comp, write, tag_in, index, offset, data_in,
      input  hit, dirty, valid, tag_out, data_out
   );

   modport way (
      input  enable, comp, write, tag_in, index, offset, data_in,
      output hit, dirty, valid, tag_out, data_out
   );

endinterface

/* src/cache_pkg.sv */
/*
 * Cache package
 * Address split, cache geometry, banked memory timing and the
 * controller state encoding shared by the data cache blocks
 */
package cache_pkg;

   // Host word and address
   localparam int addr_w = 16;
   localparam int data_w = 16;

   // Address fields: tag 15..11, index 10..3, byte offset 2..0
   localparam int tag_w    = 5;
   localparam int index_w  = 8;
   localparam int offset_w = 3;

   // Line geometry
   localparam int line_words = 4;

   // Main memory
   localparam int num_banks        = 4;
   localparam int mem_rd_lat       = 2;
   localparam int bank_busy_cycles = 4;
   localparam int mem_words        = 32768;

   // Miss handling sequence of the controller
   typedef enum logic [2:0] {
      st_idle,
      st_compare,
      st_wb,
      st_fill,
      st_fill_wait,
      st_retry,
      st_finish
   } ctrl_state_e;

endpackage
